// File: files.f
+incdir+include
hdl/soc_ctrl_pkg.sv
hdl/soc_ctrl_apb_regs.sv
hdl/pad_cfg_bank.sv
hdl/soc_watchdog.sv
hdl/ready_timeout_mon.sv
hdl/apb_soc_ctrl.sv
sim/tb_apb_soc_ctrl.sv

// File: hdl/apb_soc_ctrl.sv
// SoC control APB slave
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module apb_soc_ctrl
  import soc_ctrl_pkg::*;
(
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic [11:0]               paddr_i,
  input  logic [31:0]               pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  logic                      bootsel_i,
  input  logic                      sel_fll_clk_i,
  input  logic [`JTAG_REG_SIZE-1:0] soc_jtag_reg_i,
  output logic [`JTAG_REG_SIZE-1:0] soc_jtag_reg_o,
  output logic [31:0]               fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  output pad_cfg_t [`N_IO-1:0]      pad_cfg_o,
  output pad_mux_t [`N_IO-1:0]      pad_mux_o,
  input  logic                      wd_tick_i,
  input  logic                      stoptimer_i,
  output logic                      wd_expired_o,
  input  logic                      start_rto_i,
  input  logic [`NB_MASTER-1:0]     peripheral_rto_i,
  output logic                      rto_o,
  output logic                      soft_reset_o
);

  logic        pad_we;
  pad_idx_t    pad_idx;
  pad_cfg_t    pad_cfg_wr;
  pad_mux_t    pad_mux_wr;
  pad_idx_t    pad_rd_idx;
  pad_cfg_t    pad_cfg_rd;
  pad_mux_t    pad_mux_rd;
  logic        wd_count_we;
  logic        wd_ctrl_we;
  logic        wd_rr_clr;
  logic [31:0] wdata;
  logic [30:0] wd_count;
  logic        wd_enabled;
  logic [1:0]  reset_reason;
  logic        rto_count_we;
  logic        rto_flags_clr;
  logic [31:0] rto_count;
  logic [31:0] rto_flags;

  soc_ctrl_apb_regs u_regs (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .pwrite_i        (pwrite_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .bootsel_i       (bootsel_i),
    .sel_fll_clk_i   (sel_fll_clk_i),
    .soc_jtag_reg_i  (soc_jtag_reg_i),
    .soc_jtag_reg_o  (soc_jtag_reg_o),
    .fc_bootaddr_o   (fc_bootaddr_o),
    .fc_fetchen_o    (fc_fetchen_o),
    .soft_clr_o      (soft_reset_o),   // Soft clear also leaves the chip
    .pad_we_o        (pad_we),
    .pad_idx_o       (pad_idx),
    .pad_cfg_wr_o    (pad_cfg_wr),
    .pad_mux_wr_o    (pad_mux_wr),
    .pad_rd_idx_o    (pad_rd_idx),
    .pad_cfg_rd_i    (pad_cfg_rd),
    .pad_mux_rd_i    (pad_mux_rd),
    .wd_count_we_o   (wd_count_we),
    .wd_ctrl_we_o    (wd_ctrl_we),
    .wd_rr_clr_o     (wd_rr_clr),
    .wdata_o         (wdata),
    .wd_count_i      (wd_count),
    .wd_enabled_i    (wd_enabled),
    .reset_reason_i  (reset_reason),
    .rto_count_we_o  (rto_count_we),
    .rto_flags_clr_o (rto_flags_clr),
    .rto_count_i     (rto_count),
    .rto_flags_i     (rto_flags)
  );

  pad_cfg_bank u_pads (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .pad_we_i   (pad_we),
    .pad_idx_i  (pad_idx),
    .pad_cfg_i  (pad_cfg_wr),
    .pad_mux_i  (pad_mux_wr),
    .soft_clr_i (soft_reset_o),
    .rd_idx_i   (pad_rd_idx),
    .rd_cfg_o   (pad_cfg_rd),
    .rd_mux_o   (pad_mux_rd),
    .pad_cfg_o  (pad_cfg_o),
    .pad_mux_o  (pad_mux_o)
  );

  soc_watchdog u_wdog (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .count_we_i     (wd_count_we),
    .ctrl_we_i      (wd_ctrl_we),
    .rr_clr_i       (wd_rr_clr),
    .wdata_i        (wdata),
    .tick_i         (wd_tick_i),
    .stop_i         (stoptimer_i),
    .wd_count_o     (wd_count),
    .wd_enabled_o   (wd_enabled),
    .reset_reason_o (reset_reason),
    .wd_expired_o   (wd_expired_o)
  );

  ready_timeout_mon u_rto (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .count_we_i       (rto_count_we),
    .flags_clr_i      (rto_flags_clr),
    .soft_clr_i       (soft_reset_o),
    .wdata_i          (wdata),
    .start_rto_i      (start_rto_i),
    .peripheral_rto_i (peripheral_rto_i),
    .rto_count_o      (rto_count),
    .rto_flags_o      (rto_flags),
    .rto_o            (rto_o)
  );

endmodule

// File: hdl/pad_cfg_bank.sv
// Pad configuration bank
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module pad_cfg_bank
  import soc_ctrl_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  pad_we_i,
  input  pad_idx_t              pad_idx_i,
  input  pad_cfg_t              pad_cfg_i,
  input  pad_mux_t              pad_mux_i,
  input  logic                  soft_clr_i,
  input  pad_idx_t              rd_idx_i,
  output pad_cfg_t              rd_cfg_o,
  output pad_mux_t              rd_mux_o,
  output pad_cfg_t [`N_IO-1:0]  pad_cfg_o,
  output pad_mux_t [`N_IO-1:0]  pad_mux_o
);

  // Configuration defaults to all ones and mux to function zero
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (soft_clr_i) begin
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (pad_we_i) begin
      pad_cfg_o[pad_idx_i] <= pad_cfg_i;
      pad_mux_o[pad_idx_i] <= pad_mux_i;
    end
  end

  assign rd_cfg_o = pad_cfg_o[rd_idx_i];
  assign rd_mux_o = pad_mux_o[rd_idx_i];

  // A soft clear would swallow a write in the same cycle
  a_we_not_in_clear: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pad_we_i |-> !soft_clr_i);

endmodule

// File: hdl/ready_timeout_mon.sv
// Ready timeout monitor
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module ready_timeout_mon (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  count_we_i,
  input  logic                  flags_clr_i,
  input  logic                  soft_clr_i,
  input  logic [31:0]           wdata_i,
  input  logic                  start_rto_i,
  input  logic [`NB_MASTER-1:0] peripheral_rto_i,
  output logic [31:0]           rto_count_o,
  output logic [31:0]           rto_flags_o,
  output logic                  rto_o
);

  logic [19:0]           limit_q;
  logic [19:0]           cnt_q;
  logic [`NB_MASTER-1:0] flags_q;

  assign rto_count_o = {12'h000, limit_q};
  assign rto_flags_o = {{(32 - `NB_MASTER){1'b0}}, flags_q};

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      limit_q <= `RTO_COUNT_RST;
      cnt_q   <= `RTO_COUNT_RST;
      flags_q <= '0;
      rto_o   <= 1'b0;
    end else begin
      if (soft_clr_i) begin
        limit_q <= `RTO_COUNT_RST;
      end else if (count_we_i) begin
        limit_q <= {wdata_i[19:4], 4'hF};  // Limit never drops below 15
      end
      if (!start_rto_i) begin
        cnt_q <= limit_q;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      rto_o <= (cnt_q == '0);
      if (soft_clr_i || flags_clr_i) begin
        flags_q <= '0;
      end else begin
        flags_q <= flags_q | peripheral_rto_i;
      end
    end
  end

endmodule

// File: hdl/soc_ctrl_apb_regs.sv
// SoC control APB front end
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module soc_ctrl_apb_regs
  import soc_ctrl_pkg::*;
(
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic [11:0]               paddr_i,
  input  logic [31:0]               pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  logic                      bootsel_i,
  input  logic                      sel_fll_clk_i,
  input  logic [`JTAG_REG_SIZE-1:0] soc_jtag_reg_i,
  output logic [`JTAG_REG_SIZE-1:0] soc_jtag_reg_o,
  output logic [31:0]               fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  output logic                      soft_clr_o,
  output logic                      pad_we_o,
  output pad_idx_t                  pad_idx_o,
  output pad_cfg_t                  pad_cfg_wr_o,
  output pad_mux_t                  pad_mux_wr_o,
  output pad_idx_t                  pad_rd_idx_o,
  input  pad_cfg_t                  pad_cfg_rd_i,
  input  pad_mux_t                  pad_mux_rd_i,
  output logic                      wd_count_we_o,
  output logic                      wd_ctrl_we_o,
  output logic                      wd_rr_clr_o,
  output logic [31:0]               wdata_o,
  input  logic [30:0]               wd_count_i,
  input  logic                      wd_enabled_i,
  input  logic [1:0]                reset_reason_i,
  output logic                      rto_count_we_o,
  output logic                      rto_flags_clr_o,
  input  logic [31:0]               rto_count_i,
  input  logic [31:0]               rto_flags_i
);

  apb_state_t                state_q;
  pad_idx_t                  pad_idx_q;
  logic [`JTAG_REG_SIZE-1:0] jtag_meta_q;
  logic [`JTAG_REG_SIZE-1:0] jtag_sync_q;
  logic                      bootsel_q;
  logic                      bootsel_vld_q;
  logic                      win_hit;
  logic                      win_ok;
  logic                      boot_we;
  logic                      fetch_we;
  logic                      jtag_we;
  logic                      idx_we;
  logic                      wr_err;
  logic [31:0]               rd_data;
  logic                      rd_err;

  assign win_hit = (paddr_i[11:10] == `PAD_WINDOW_TAG);
  assign win_ok  = (paddr_i[9:2] < `N_IO);  // Window spans 256 slots, only N_IO exist

  // The window takes the pad from the address, the indexed registers from the data
  assign pad_idx_o    = win_hit ? paddr_i[2 +: `PAD_IDX_W] : pwdata_i[0 +: `PAD_IDX_W];
  assign pad_cfg_wr_o = win_hit ? pwdata_i[8 +: `NBIT_PADCFG] : pwdata_i[24 +: `NBIT_PADCFG];
  assign pad_mux_wr_o = win_hit ? pwdata_i[0 +: `NBIT_PADMUX] : pwdata_i[16 +: `NBIT_PADMUX];
  assign pad_rd_idx_o = win_hit ? paddr_i[2 +: `PAD_IDX_W] : pad_idx_q;
  assign wdata_o      = pwdata_i;

  // Write strobes, valid for the single cycle spent in APB_WRITE
  always_comb begin
    boot_we         = 1'b0;
    fetch_we        = 1'b0;
    jtag_we         = 1'b0;
    idx_we          = 1'b0;
    pad_we_o        = 1'b0;
    wd_count_we_o   = 1'b0;
    wd_ctrl_we_o    = 1'b0;
    wd_rr_clr_o     = 1'b0;
    rto_count_we_o  = 1'b0;
    rto_flags_clr_o = 1'b0;
    soft_clr_o      = 1'b0;
    wr_err          = 1'b0;
    if (state_q == APB_WRITE) begin
      if (win_hit) begin
        pad_we_o = win_ok;  // Out of range writes are dropped silently
        idx_we   = win_ok;
      end else begin
        case (paddr_i)
          `REG_FCBOOT:         boot_we = 1'b1;
          `REG_FCFETCH:        fetch_we = 1'b1;
          `REG_WCFGFUN: begin
            pad_we_o = 1'b1;
            idx_we   = 1'b1;
          end
          `REG_RCFGFUN:        idx_we = 1'b1;
          `REG_JTAGREG:        jtag_we = 1'b1;
          `REG_WD_COUNT:       wd_count_we_o = 1'b1;
          `REG_WD_CONTROL:     wd_ctrl_we_o = 1'b1;
          `REG_RESET_REASON:   wd_rr_clr_o = 1'b1;
          `REG_RTO_PERIPHERAL: rto_flags_clr_o = 1'b1;
          `REG_RTO_COUNT:      rto_count_we_o = 1'b1;
          `REG_SOFT_RESET:     soft_clr_o = 1'b1;
          default:             wr_err = 1'b1;
        endcase
      end
    end else if (state_q == APB_READ) begin
      idx_we = win_hit && win_ok;  // A window read also moves the current pad
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (win_hit) begin
      if (win_ok) begin
        rd_data[0 +: `NBIT_PADMUX] = pad_mux_rd_i;
        rd_data[8 +: `NBIT_PADCFG] = pad_cfg_rd_i;
      end else begin
        rd_data = `PAD_RANGE_ERR;
      end
    end else begin
      case (paddr_i)
        `REG_INFO:           rd_data = {`NB_CORES, `NB_CLUSTERS};
        `REG_FCBOOT:         rd_data = fc_bootaddr_o;
        `REG_FCFETCH:        rd_data = {31'h0, fc_fetchen_o};
        `REG_WCFGFUN, `REG_RCFGFUN: begin
          rd_data[0 +: `PAD_IDX_W]    = pad_idx_q;
          rd_data[16 +: `NBIT_PADMUX] = pad_mux_rd_i;
          rd_data[24 +: `NBIT_PADCFG] = pad_cfg_rd_i;
        end
        `REG_JTAGREG:
          rd_data = {{(32 - 2 * `JTAG_REG_SIZE){1'b0}}, jtag_sync_q, soc_jtag_reg_o};
        `REG_BOOTSEL:        rd_data = {bootsel_i, 30'h0, bootsel_q};
        `REG_CLKSEL:         rd_data = {31'h0, sel_fll_clk_i};
        `REG_WD_COUNT:       rd_data = {1'b0, wd_count_i};
        `REG_WD_CONTROL:     rd_data = {wd_enabled_i, wd_count_i};
        `REG_RESET_REASON:   rd_data = {30'h0, reset_reason_i};
        `REG_RTO_PERIPHERAL: rd_data = rto_flags_i;
        `REG_RTO_COUNT:      rd_data = rto_count_i;
        default: begin
          rd_data = `RD_ERR_DATA;
          rd_err  = 1'b1;
        end
      endcase
    end
  end

  // Access FSM, pready_o two edges after the sampling edge
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= APB_IDLE;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      prdata_o  <= '0;
    end else begin
      case (state_q)
        APB_IDLE: begin
          pslverr_o <= 1'b0;
          if (psel_i && penable_i) begin
            state_q <= pwrite_i ? APB_WRITE : APB_READ;
          end
        end
        APB_READ: begin
          pready_o  <= 1'b1;
          prdata_o  <= rd_data;
          pslverr_o <= rd_err;
          state_q   <= APB_WAIT;
        end
        APB_WRITE: begin
          pready_o  <= 1'b1;
          pslverr_o <= wr_err;
          state_q   <= APB_WAIT;
        end
        default: begin
          pready_o <= 1'b0;
          state_q  <= APB_IDLE;
        end
      endcase
    end
  end

  // Local registers
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fc_bootaddr_o  <= `BOOTADDR_RST;
      fc_fetchen_o   <= 1'b1;           // FC runs out of reset
      soc_jtag_reg_o <= '0;
      jtag_meta_q    <= '0;
      jtag_sync_q    <= '0;
      bootsel_q      <= 1'b0;
      bootsel_vld_q  <= 1'b0;
      pad_idx_q      <= '0;
    end else begin
      jtag_meta_q <= soc_jtag_reg_i;
      jtag_sync_q <= jtag_meta_q;
      if (!bootsel_vld_q) begin        // Capture the boot mode once after reset
        bootsel_q     <= bootsel_i;
        bootsel_vld_q <= 1'b1;
      end
      if (boot_we) fc_bootaddr_o <= pwdata_i;
      if (fetch_we) fc_fetchen_o <= pwdata_i[0];
      if (jtag_we) soc_jtag_reg_o <= pwdata_i[`JTAG_REG_SIZE-1:0];
      if (soft_clr_o) begin
        pad_idx_q <= '0;
      end else if (idx_we) begin
        pad_idx_q <= pad_idx_o;
      end
    end
  end

  a_pready_single: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pready_o |=> !pready_o);

  a_pready_in_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(pready_o) |-> (state_q == APB_WAIT));

endmodule

// File: hdl/soc_ctrl_pkg.sv
// SoC control types
`include "soc_ctrl_defines.svh"

package soc_ctrl_pkg;

  // APB access sequence, one pass per transfer
  typedef enum logic [1:0] {
    APB_IDLE  = 2'd0,
    APB_READ  = 2'd1,
    APB_WRITE = 2'd2,
    APB_WAIT  = 2'd3
  } apb_state_t;

  typedef logic [`NBIT_PADCFG-1:0] pad_cfg_t;  // Drive strength, pulls and so on
  typedef logic [`NBIT_PADMUX-1:0] pad_mux_t;  // Alternate function select
  typedef logic [`PAD_IDX_W-1:0]   pad_idx_t;

endpackage

// File: hdl/soc_watchdog.sv
// Tick driven watchdog
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module soc_watchdog (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        count_we_i,
  input  logic        ctrl_we_i,
  input  logic        rr_clr_i,
  input  logic [31:0] wdata_i,
  input  logic        tick_i,
  input  logic        stop_i,
  output logic [30:0] wd_count_o,
  output logic        wd_enabled_o,
  output logic [1:0]  reset_reason_o,
  output logic        wd_expired_o
);

  logic [30:0] cur_q;
  logic        at_zero;

  assign at_zero = (cur_q == '0);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_count_o     <= `WD_COUNT_RST;
      cur_q          <= `WD_COUNT_RST;
      wd_enabled_o   <= 1'b0;
      wd_expired_o   <= 1'b0;
      reset_reason_o <= 2'b01;  // Bit 0 marks a power-on reset
    end else begin
      if (count_we_i && !wd_enabled_o) begin
        wd_count_o <= wdata_i[30:0];  // Load is frozen once armed
      end
      if (ctrl_we_i && wdata_i[0]) begin  // The kick code has bit 0 set and reloads here too
        wd_enabled_o <= 1'b1;
        cur_q        <= wd_count_o;
      end else if (wd_enabled_o && tick_i && !stop_i && !at_zero) begin
        cur_q <= cur_q - 1'b1;
      end
      if (rr_clr_i) begin
        reset_reason_o <= 2'b00;
      end else if (wd_enabled_o && at_zero) begin
        reset_reason_o <= 2'b10;
      end
      if (wd_enabled_o && at_zero) wd_expired_o <= 1'b1;
    end
  end

  // Only HRESETn clears the expiry
  a_expired_sticky: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wd_expired_o |=> wd_expired_o);

endmodule

// File: include/soc_ctrl_defines.svh
// SoC control register map
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

// Register offsets in the 4 KB window
`define REG_INFO            12'h000
`define REG_FCBOOT          12'h004
`define REG_FCFETCH         12'h008
`define REG_WCFGFUN         12'h060
`define REG_RCFGFUN         12'h064
`define REG_JTAGREG         12'h074
`define REG_BOOTSEL         12'h0C4
`define REG_CLKSEL          12'h0C8
`define REG_WD_COUNT        12'h0D0
`define REG_WD_CONTROL      12'h0D4
`define REG_RESET_REASON    12'h0D8
`define REG_RTO_PERIPHERAL  12'h0E0
`define REG_RTO_COUNT       12'h0E4
`define REG_SOFT_RESET      12'h0FC

`define PAD_WINDOW_TAG      2'b01     // Address bits 11:10 of the pad window at 0x400

// Pad bank geometry
`define N_IO                64
`define PAD_IDX_W           6
`define NBIT_PADCFG         6
`define NBIT_PADMUX         2

`define NB_MASTER           4         // Masters watched for ready timeouts
`define JTAG_REG_SIZE       8

// Reset values
`define BOOTADDR_RST        32'h1A00_0080
`define RTO_COUNT_RST       20'h000FF
`define WD_COUNT_RST        31'd32768

`define WD_KICK             16'h6699  // Reloads the running watchdog

// Fixed read data
`define RD_ERR_DATA         32'hDEAD_BEEF
`define PAD_RANGE_ERR       32'h0095_BEEF
`define NB_CORES            16'd4
`define NB_CLUSTERS         16'd0

`endif

// File: sim/tb_apb_soc_ctrl.sv
// SoC control testbench
`timescale 1ns/100ps
`include "soc_ctrl_defines.svh"

module tb_apb_soc_ctrl;

  localparam int          TIMEOUT_NS = 20000;  // Nearly three times the 900 cycle run
  localparam logic [30:0] WD_LOAD    = 31'd100;

  logic                               HCLK;
  logic                               HRESETn;
  logic [11:0]                        paddr_i;
  logic [31:0]                        pwdata_i;
  logic                               pwrite_i;
  logic                               psel_i;
  logic                               penable_i;
  logic [31:0]                        prdata_o;
  logic                               pready_o;
  logic                               pslverr_o;
  logic                               bootsel_i;
  logic                               sel_fll_clk_i;
  logic [`JTAG_REG_SIZE-1:0]          soc_jtag_reg_i;
  logic [`JTAG_REG_SIZE-1:0]          soc_jtag_reg_o;
  logic [31:0]                        fc_bootaddr_o;
  logic                               fc_fetchen_o;
  logic [`N_IO-1:0][`NBIT_PADCFG-1:0] pad_cfg_o;
  logic [`N_IO-1:0][`NBIT_PADMUX-1:0] pad_mux_o;
  logic                               wd_tick_i;
  logic                               stoptimer_i;
  logic                               wd_expired_o;
  logic                               start_rto_i;
  logic [`NB_MASTER-1:0]              peripheral_rto_i;
  logic                               rto_o;
  logic                               soft_reset_o;

  integer      seed;
  int          errors      = 0;
  int          rsp_count   = 0;
  int          soft_pulses = 0;
  int          n;
  int          pulses_before;
  logic        pready_prev = 1'b0;
  logic [31:0] exp_data;
  logic        exp_err;
  logic        exp_rd;
  logic [31:0] rnd;

  // Register model
  logic [31:0]             m_bootaddr;
  logic                    m_fetchen;
  logic [7:0]              m_jtag_out;
  logic [7:0]              m_jtag_in;
  logic [`NBIT_PADCFG-1:0] m_cfg [0:`N_IO-1];
  logic [`NBIT_PADMUX-1:0] m_mux [0:`N_IO-1];
  logic [`PAD_IDX_W-1:0]   m_idx;
  logic [30:0]             m_wd_load;
  logic                    m_wd_en;
  logic [1:0]              m_rr;
  logic [19:0]             m_limit;
  logic [3:0]              m_flags;

  apb_soc_ctrl u_apb_soc_ctrl (.*);

  initial begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
    errors++;
  endtask

  task automatic soft_clear_model();
    int i;
    for (i = 0; i < `N_IO; i++) begin
      m_cfg[i] = '1;
      m_mux[i] = '0;
    end
    m_idx   = '0;
    m_limit = `RTO_COUNT_RST;
    m_flags = 4'h0;
  endtask

  task automatic reset_model();
    m_bootaddr = `BOOTADDR_RST;
    m_fetchen  = 1'b1;
    m_jtag_out = 8'h00;
    m_wd_load  = `WD_COUNT_RST;
    m_wd_en    = 1'b0;
    m_rr       = 2'b01;  // Power-on reason
    soft_clear_model();
  endtask

  task automatic update_model(input logic [11:0] addr, input logic [31:0] data);
    if (addr[11:10] == `PAD_WINDOW_TAG) begin
      if (addr[9:2] < `N_IO) begin
        m_cfg[addr[7:2]] = data[13:8];
        m_mux[addr[7:2]] = data[1:0];
        m_idx            = addr[7:2];
      end
    end else begin
      case (addr)
        `REG_FCBOOT:         m_bootaddr = data;
        `REG_FCFETCH:        m_fetchen = data[0];
        `REG_WCFGFUN: begin
          m_idx            = data[5:0];
          m_cfg[data[5:0]] = data[29:24];
          m_mux[data[5:0]] = data[17:16];
        end
        `REG_RCFGFUN:        m_idx = data[5:0];
        `REG_JTAGREG:        m_jtag_out = data[7:0];
        `REG_WD_COUNT: begin
          if (!m_wd_en) m_wd_load = data[30:0];  // Load freezes once armed
        end
        `REG_WD_CONTROL: begin
          if (data[0]) m_wd_en = 1'b1;
        end
        `REG_RESET_REASON:   m_rr = 2'b00;
        `REG_RTO_PERIPHERAL: m_flags = 4'h0;
        `REG_RTO_COUNT:      m_limit = {data[19:4], 4'hF};
        `REG_SOFT_RESET:     soft_clear_model();
        default:             ;
      endcase
    end
  endtask

  // Expected {pslverr, prdata} of an access from the register model
  function automatic logic [32:0] expect_resp(input logic [11:0] addr, input logic wr);
    logic [31:0] d;
    logic        known;
    d     = 32'h0;
    known = 1'b1;
    if (addr[11:10] == `PAD_WINDOW_TAG) begin
      if (addr[9:2] < `N_IO) d = {18'h0, m_cfg[addr[7:2]], 6'h0, m_mux[addr[7:2]]};
      else d = `PAD_RANGE_ERR;
    end else begin
      case (addr)
        `REG_INFO:           d = 32'h0004_0000;  // Four cores and no clusters
        `REG_FCBOOT:         d = m_bootaddr;
        `REG_FCFETCH:        d = {31'h0, m_fetchen};
        `REG_WCFGFUN, `REG_RCFGFUN:
          d = {2'b0, m_cfg[m_idx], 6'h0, m_mux[m_idx], 10'h0, m_idx};
        `REG_JTAGREG:        d = {16'h0, m_jtag_in, m_jtag_out};
        `REG_BOOTSEL:        d = {bootsel_i, 30'h0, bootsel_i};
        `REG_CLKSEL:         d = {31'h0, sel_fll_clk_i};
        `REG_WD_COUNT:       d = {1'b0, m_wd_load};
        `REG_WD_CONTROL:     d = {m_wd_en, m_wd_load};
        `REG_RESET_REASON:   d = {30'h0, m_rr};
        `REG_RTO_PERIPHERAL: d = {28'h0, m_flags};
        `REG_RTO_COUNT:      d = {12'h0, m_limit};
        `REG_SOFT_RESET:     known = wr;
        default:             known = 1'b0;
      endcase
      if (wr && (addr == `REG_INFO || addr == `REG_BOOTSEL || addr == `REG_CLKSEL)) known = 1'b0;
      if (!known) d = `RD_ERR_DATA;
    end
    return {!known, d};
  endfunction

  // One APB transfer that ends one edge after pready_o
  task automatic run_transfer(input logic [11:0] addr, input logic [31:0] data, input logic wr);
    int edges;
    @(posedge HCLK);
    paddr_i   <= addr;
    pwdata_i  <= data;
    pwrite_i  <= wr;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge HCLK);
    penable_i <= 1'b1;
    @(posedge HCLK);                 // Slave samples the access here
    edges = 0;
    while (!pready_o && edges < 16) begin
      @(posedge HCLK);
      edges++;
    end
    if (!pready_o) begin
      $display("ERROR at %0t ns: no pready_o for address 0x%h", $time, addr);
      errors++;
    end else if (edges != 2) begin
      report_mismatch("pready_o latency", 32'd2, edges);
    end
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    @(posedge HCLK);
  endtask

  task automatic apb_read(input logic [11:0] addr);
    logic [32:0] resp;
    resp     = expect_resp(addr, 1'b0);
    exp_err  = resp[32];
    exp_data = resp[31:0];
    exp_rd   = 1'b1;
    run_transfer(addr, 32'h0, 1'b0);
    if ((addr[11:10] == `PAD_WINDOW_TAG) && (addr[9:2] < `N_IO))
      m_idx = addr[7:2];             // A window read moves the current pad
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [32:0] resp;
    resp     = expect_resp(addr, 1'b1);
    exp_err  = resp[32];
    exp_data = resp[31:0];
    exp_rd   = 1'b0;
    run_transfer(addr, data, 1'b1);
    update_model(addr, data);
  endtask

  task automatic check_outputs();
    int i;
    if (fc_bootaddr_o !== m_bootaddr)
      report_mismatch("fc_bootaddr_o", m_bootaddr, fc_bootaddr_o);
    if (fc_fetchen_o !== m_fetchen)
      report_mismatch("fc_fetchen_o", m_fetchen, fc_fetchen_o);
    if (soc_jtag_reg_o !== m_jtag_out)
      report_mismatch("soc_jtag_reg_o", m_jtag_out, soc_jtag_reg_o);
    for (i = 0; i < `N_IO; i++) begin
      if (pad_cfg_o[i] !== m_cfg[i])
        report_mismatch($sformatf("pad_cfg_o[%0d]", i), m_cfg[i], pad_cfg_o[i]);
      if (pad_mux_o[i] !== m_mux[i])
        report_mismatch($sformatf("pad_mux_o[%0d]", i), m_mux[i], pad_mux_o[i]);
    end
  endtask

  task automatic apply_reset();
    @(posedge HCLK);
    HRESETn <= 1'b0;
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    reset_model();
  endtask

  // Response comparator
  always @(posedge HCLK) begin
    if (pready_o) begin
      rsp_count++;
      if (pslverr_o !== exp_err) report_mismatch("pslverr_o", exp_err, pslverr_o);
      if (exp_rd && (prdata_o !== exp_data)) report_mismatch("prdata_o", exp_data, prdata_o);
      if (pready_prev) begin
        $display("ERROR at %0t ns: pready_o high for more than one cycle", $time);
        errors++;
      end
    end
    pready_prev = pready_o;
  end

  always @(posedge HCLK) begin
    if (soft_reset_o) soft_pulses++;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d errors", TIMEOUT_NS, errors);
    $display("Verification failed");
    $finish;
  end

  initial begin
    seed             = 78;
    HRESETn          = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    pwrite_i         = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    bootsel_i        = 1'b1;
    sel_fll_clk_i    = 1'b1;
    soc_jtag_reg_i   = '0;
    wd_tick_i        = 1'b0;
    stoptimer_i      = 1'b0;
    start_rto_i      = 1'b0;
    peripheral_rto_i = '0;
    m_jtag_in        = 8'h00;
    apply_reset();

    // Reset values and basic registers
    check_outputs();
    if (wd_expired_o || rto_o || soft_reset_o || pready_o || pslverr_o) begin
      $display("ERROR at %0t ns: status outputs not low after reset", $time);
      errors++;
    end
    apb_read(`REG_INFO);
    apb_read(`REG_BOOTSEL);
    apb_read(`REG_CLKSEL);
    apb_write(`REG_FCBOOT, $random(seed));
    apb_read(`REG_FCBOOT);
    apb_write(`REG_FCFETCH, 32'h0);
    apb_read(`REG_FCFETCH);
    check_outputs();

    // Pads through the indexed pair and the window
    repeat (8) begin
      apb_write(`REG_WCFGFUN, $random(seed));
      apb_read(`REG_RCFGFUN);
      rnd = $random(seed);
      apb_write({2'b01, 2'b00, rnd[5:0], 2'b00}, $random(seed));
      rnd = $random(seed);
      apb_read({2'b01, 2'b00, rnd[5:0], 2'b00});
      apb_read(`REG_WCFGFUN);
    end
    check_outputs();
    rnd = $random(seed);
    apb_read({2'b01, 8'd64 + (rnd[7:0] % 8'd192), 2'b00});

    // Unmapped accesses
    apb_read(12'h010);
    apb_read(12'h800);
    apb_write(12'h010, 32'hFFFF_FFFF);
    apb_write(`REG_INFO, 32'h1234_5678);
    check_outputs();

    // Watchdog runs out
    apb_write(`REG_WD_COUNT, {1'b0, WD_LOAD});
    apb_read(`REG_WD_COUNT);
    wd_tick_i <= 1'b1;
    apb_write(`REG_WD_CONTROL, 32'h1);
    if (wd_expired_o) begin
      $display("ERROR at %0t ns: watchdog expired right after enable", $time);
      errors++;
    end
    n = 0;
    while (!wd_expired_o && n < int'(WD_LOAD) + 16) begin
      @(posedge HCLK);
      n++;
    end
    if (!wd_expired_o || n < int'(WD_LOAD) - 4) begin
      $display("ERROR at %0t ns: watchdog expiry not in the expected window (%0d cycles)",
               $time, n);
      errors++;
    end
    m_rr = 2'b10;
    apb_read(`REG_RESET_REASON);
    apb_read(`REG_WD_CONTROL);
    wd_tick_i <= 1'b0;

    // Watchdog kept alive by kicks
    apply_reset();
    apb_write(`REG_WD_COUNT, 32'd40);
    wd_tick_i <= 1'b1;
    apb_write(`REG_WD_CONTROL, 32'h1);
    repeat (10) begin
      repeat (20) @(posedge HCLK);
      apb_write(`REG_WD_CONTROL, {16'h0, `WD_KICK});
    end
    if (wd_expired_o) begin
      $display("ERROR at %0t ns: watchdog expired although kicked", $time);
      errors++;
    end
    wd_tick_i <= 1'b0;

    // Ready timeout
    apb_write(`REG_RTO_COUNT, 32'hABC0_0040);  // Limit becomes 0x4F
    apb_read(`REG_RTO_COUNT);
    if (rto_o) begin
      $display("ERROR at %0t ns: rto_o high before start", $time);
      errors++;
    end
    start_rto_i <= 1'b1;
    n = 0;
    while (!rto_o && n < int'(m_limit) + 8) begin
      @(posedge HCLK);
      n++;
    end
    if (!rto_o || n < int'(m_limit)) begin
      $display("ERROR at %0t ns: rto_o not seen in the expected window (%0d cycles)", $time, n);
      errors++;
    end
    start_rto_i <= 1'b0;
    peripheral_rto_i <= 4'b1010;
    @(posedge HCLK);
    peripheral_rto_i <= 4'b0000;
    m_flags = m_flags | 4'b1010;
    apb_read(`REG_RTO_PERIPHERAL);
    apb_write(`REG_RTO_PERIPHERAL, 32'h0);
    apb_read(`REG_RTO_PERIPHERAL);

    // Soft reset and JTAG exchange
    apb_write(`REG_FCBOOT, $random(seed));
    repeat (4) apb_write(`REG_WCFGFUN, $random(seed));
    pulses_before = soft_pulses;
    apb_write(`REG_SOFT_RESET, 32'h1);
    if (soft_pulses != pulses_before + 1) begin
      $display("ERROR at %0t ns: soft_reset_o did not pulse exactly once", $time);
      errors++;
    end
    check_outputs();
    apb_read(`REG_RTO_COUNT);
    apb_read(`REG_RCFGFUN);
    rnd = $random(seed);
    soc_jtag_reg_i <= rnd[15:8];
    m_jtag_in = rnd[15:8];
    apb_write(`REG_JTAGREG, rnd);
    repeat (4) @(posedge HCLK);
    apb_read(`REG_JTAGREG);
    check_outputs();

    $display("Responses checked: %0d, errors: %0d", rsp_count, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
